/* tb.f */
rtl/sb_pkg.sv
rtl/sb_entry_store.sv
rtl/sb_clobber_table.sv
rtl/sb_operand_fwd.sv
rtl/scoreboard.sv
tests/scoreboard_sva.sv
tests/scoreboard_tb.sv

/* tests/scoreboard_tb.sv */
// testbench for the scoreboard driven from a per-cycle stimulus and expectation table
`timescale 1ns/1ps

module scoreboard_tb;

  localparam int unsigned NR_ENTRIES  = 8;
  localparam int unsigned NR_WB_PORTS = 2;
  localparam int unsigned MAX_ROWS    = 40;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic flush_i = 1'b0;
  logic dec_valid_i = 1'b0;
  logic [4:0] dec_rd_i = '0;
  sb_pkg::fu_e dec_fu_i = sb_pkg::FU_NONE;
  logic issue_ack_i = 1'b0;
  logic issue_valid_o, dec_ack_o, sb_full_o;
  logic [2:0] issue_trans_id_o;
  logic [1:0] wb_valid_i = '0;
  logic [1:0][2:0] wb_trans_id_i = '0;
  logic [1:0][31:0] wb_data_i = '0;
  logic commit_valid_o;
  logic [2:0] commit_trans_id_o;
  logic [4:0] commit_rd_o;
  sb_pkg::fu_e commit_fu_o;
  logic [31:0] commit_result_o;
  logic commit_ack_i = 1'b0;
  logic [4:0] rs1_i = '0;
  logic [4:0] rs2_i = '0;
  logic [31:0] rs1_o, rs2_o;
  logic rs1_valid_o, rs2_valid_o;
  sb_pkg::fu_e [31:0] rd_clobber_o;

  // ----------------------------------------------------------
  // stimulus table with one row per cycle
  // ----------------------------------------------------------
  int n_rows = 0;
  bit table_ready = 1'b0;
  int t_test [MAX_ROWS];
  logic t_dv [MAX_ROWS];
  logic t_ack [MAX_ROWS];
  logic [4:0] t_rd [MAX_ROWS];
  sb_pkg::fu_e t_fu [MAX_ROWS];
  logic [1:0] t_wbv [MAX_ROWS];
  logic [2:0] t_wbid [MAX_ROWS][2];
  logic [31:0] t_wbd [MAX_ROWS][2];
  logic t_cack [MAX_ROWS];
  logic t_flush [MAX_ROWS];
  logic [4:0] t_rs1 [MAX_ROWS];
  logic [4:0] t_rs2 [MAX_ROWS];
  // expected columns where each group has its own enable flag
  bit f_iss [MAX_ROWS];
  logic [2:0] e_id [MAX_ROWS];
  logic e_full [MAX_ROWS];
  logic e_ack [MAX_ROWS];
  bit f_cmt [MAX_ROWS];
  logic e_cv [MAX_ROWS];
  logic [2:0] e_cid [MAX_ROWS];
  logic [4:0] e_crd [MAX_ROWS];
  sb_pkg::fu_e e_cfu [MAX_ROWS];
  logic [31:0] e_cres [MAX_ROWS];
  bit f_rs [MAX_ROWS];
  logic e_r1v [MAX_ROWS];
  logic e_r2v [MAX_ROWS];
  logic [31:0] e_r1 [MAX_ROWS];
  logic [31:0] e_r2 [MAX_ROWS];
  bit f_clb [MAX_ROWS];
  bit f_clb_none [MAX_ROWS];
  logic [4:0] e_creg [MAX_ROWS];
  sb_pkg::fu_e e_cfu_reg [MAX_ROWS];

  int seed = 32'h8209eb9b;
  logic [31:0] wdata [10];
  int errors = 0;
  int checks = 0;
  int test_errors = 0;
  string test_name [7];

  scoreboard #(
    .NR_ENTRIES  (NR_ENTRIES),
    .NR_WB_PORTS (NR_WB_PORTS)
  ) scoreboard_inst (.*);

  always #4 clk_i = ~clk_i;

  task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, msg, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic new_row(input int test);
    t_test[n_rows] = test;
    t_dv[n_rows] = 0;
    t_ack[n_rows] = 0;
    t_rd[n_rows] = '0;
    t_fu[n_rows] = sb_pkg::FU_NONE;
    t_wbv[n_rows] = '0;
    t_wbid[n_rows] = '{3'd0, 3'd0};
    t_wbd[n_rows] = '{32'd0, 32'd0};
    t_cack[n_rows] = 0;
    t_flush[n_rows] = 0;
    t_rs1[n_rows] = '0;
    t_rs2[n_rows] = '0;
    f_iss[n_rows] = 0;
    f_cmt[n_rows] = 0;
    f_rs[n_rows] = 0;
    f_clb[n_rows] = 0;
    f_clb_none[n_rows] = 0;
    n_rows++;
  endtask

  task automatic issue(input logic [4:0] rd, input sb_pkg::fu_e fu, input logic ack);
    t_dv[n_rows-1] = 1;
    t_ack[n_rows-1] = ack;
    t_rd[n_rows-1] = rd;
    t_fu[n_rows-1] = fu;
  endtask

  task automatic writeback(input int p, input logic [2:0] id, input logic [31:0] d);
    t_wbv[n_rows-1][p] = 1;
    t_wbid[n_rows-1][p] = id;
    t_wbd[n_rows-1][p] = d;
  endtask

  task automatic expect_issue(input logic [2:0] id, input logic full, input logic ack);
    f_iss[n_rows-1] = 1;
    e_id[n_rows-1] = id;
    e_full[n_rows-1] = full;
    e_ack[n_rows-1] = ack;
  endtask

  task automatic expect_commit(input logic v, input logic [2:0] id, input logic [4:0] rd,
                               input sb_pkg::fu_e fu, input logic [31:0] res);
    f_cmt[n_rows-1] = 1;
    e_cv[n_rows-1] = v;
    e_cid[n_rows-1] = id;
    e_crd[n_rows-1] = rd;
    e_cfu[n_rows-1] = fu;
    e_cres[n_rows-1] = res;
  endtask

  task automatic expect_rs(input logic v1, input logic [31:0] d1,
                           input logic v2, input logic [31:0] d2);
    f_rs[n_rows-1] = 1;
    e_r1v[n_rows-1] = v1;
    e_r1[n_rows-1] = d1;
    e_r2v[n_rows-1] = v2;
    e_r2[n_rows-1] = d2;
  endtask

  task automatic expect_clobber(input logic [4:0] r, input sb_pkg::fu_e fu);
    f_clb[n_rows-1] = 1;
    e_creg[n_rows-1] = r;
    e_cfu_reg[n_rows-1] = fu;
  endtask

  task automatic build_table();
    for (int i = 0; i < 10; i++) begin
      wdata[i] = $random(seed);
    end
    // issue until full while IDs count up from 0
    for (int i = 0; i < 7; i++) begin
      new_row(1);
      issue(5'(i + 1), sb_pkg::FU_ALU, 1);
      expect_issue(3'(i), 0, 1);
      if (i == 1) expect_clobber(1, sb_pkg::FU_ALU);
    end
    for (int i = 0; i < 2; i++) begin
      new_row(1);
      issue(8, sb_pkg::FU_ALU, 0);
      expect_issue(7, 1, 0);
    end
    expect_commit(0, 0, 0, sb_pkg::FU_NONE, 0);
    // out-of-order write-back followed by in-order commit
    new_row(2);
    writeback(0, 2, wdata[2]);
    writeback(1, 1, wdata[1]);
    expect_commit(0, 0, 0, sb_pkg::FU_NONE, 0);
    new_row(2);
    writeback(0, 0, wdata[0]);
    expect_commit(0, 0, 0, sb_pkg::FU_NONE, 0);
    for (int i = 0; i < 3; i++) begin
      new_row(2);
      t_cack[n_rows-1] = 1;
      expect_commit(1, 3'(i), 5'(i + 1), sb_pkg::FU_ALU, wdata[i]);
      if (i < 2) expect_clobber(1, i == 0 ? sb_pkg::FU_ALU : sb_pkg::FU_NONE);
    end
    new_row(2);
    expect_commit(0, 0, 0, sb_pkg::FU_NONE, 0);
    // FU_NONE entry completes by itself one cycle after issue
    new_row(3);
    issue(13, sb_pkg::FU_NONE, 1);
    writeback(0, 3, wdata[3]);
    writeback(1, 4, wdata[4]);
    expect_issue(7, 0, 1);
    new_row(3);
    writeback(0, 5, wdata[5]);
    writeback(1, 6, wdata[6]);
    t_rs1[n_rows-1] = 13;
    expect_rs(0, 0, 0, 0);
    for (int i = 3; i < 8; i++) begin
      if (i > 3) new_row(3);
      t_cack[n_rows-1] = 1;
      if (i == 4) begin
        t_rs1[n_rows-1] = 13;
        expect_rs(1, 0, 0, 0);
      end
      if (i < 7) expect_commit(1, 3'(i), 5'(i + 1), sb_pkg::FU_ALU, wdata[i]);
      else expect_commit(1, 7, 13, sb_pkg::FU_NONE, 0);
    end
    new_row(3);
    expect_commit(0, 0, 0, sb_pkg::FU_NONE, 0);
    // two writers of x9 and a real unit aimed at x0
    new_row(4);
    issue(9, sb_pkg::FU_ALU, 1);
    expect_issue(0, 0, 1);
    new_row(4);
    issue(9, sb_pkg::FU_LOAD, 1);
    expect_issue(1, 0, 1);
    expect_clobber(9, sb_pkg::FU_ALU);
    new_row(4);
    issue(0, sb_pkg::FU_CSR, 1);
    expect_issue(2, 0, 1);
    new_row(4);
    expect_clobber(0, sb_pkg::FU_NONE);
    // write-back bypass against stored results
    new_row(5);
    writeback(0, 0, wdata[7]);
    t_rs1[n_rows-1] = 9;
    t_rs2[n_rows-1] = 10;
    expect_rs(1, wdata[7], 0, 0);
    new_row(5);
    writeback(1, 2, wdata[9]);
    t_rs1[n_rows-1] = 9;
    expect_rs(1, wdata[7], 0, 0);
    new_row(5);
    writeback(1, 1, wdata[8]);
    t_rs1[n_rows-1] = 9;
    t_rs2[n_rows-1] = 9;
    expect_rs(1, wdata[8], 1, wdata[8]);
    new_row(5);
    issue(11, sb_pkg::FU_ALU, 1);
    expect_issue(3, 0, 1);
    t_rs1[n_rows-1] = 9;
    t_rs2[n_rows-1] = 9;
    expect_rs(1, wdata[7], 1, wdata[7]);
    new_row(5);
    t_rs1[n_rows-1] = 11;
    t_rs2[n_rows-1] = 9;
    expect_rs(0, 0, 1, wdata[7]);
    // full flush
    new_row(6);
    t_flush[n_rows-1] = 1;
    expect_commit(1, 0, 9, sb_pkg::FU_ALU, wdata[7]);
    new_row(6);
    issue(12, sb_pkg::FU_ALU, 1);
    expect_issue(0, 0, 1);
    expect_commit(0, 0, 0, sb_pkg::FU_NONE, 0);
    f_clb_none[n_rows-1] = 1;
    new_row(6);
    expect_clobber(12, sb_pkg::FU_ALU);
    expect_commit(0, 0, 0, sb_pkg::FU_NONE, 0);
  endtask

  task automatic check_row(input int r);
    if (f_iss[r]) begin
      compare(issue_trans_id_o, e_id[r], "issue_trans_id_o");
      compare(sb_full_o, e_full[r], "sb_full_o");
      compare(dec_ack_o, e_ack[r], "dec_ack_o");
      compare(issue_valid_o, e_ack[r], "issue_valid_o");
    end
    if (f_cmt[r]) begin
      compare(commit_valid_o, e_cv[r], "commit_valid_o");
      if (e_cv[r]) begin
        compare(commit_trans_id_o, e_cid[r], "commit_trans_id_o");
        compare(commit_rd_o, e_crd[r], "commit_rd_o");
        compare(commit_fu_o, e_cfu[r], "commit_fu_o");
        compare(commit_result_o, e_cres[r], "commit_result_o");
      end
    end
    if (f_rs[r]) begin
      compare(rs1_valid_o, e_r1v[r], "rs1_valid_o");
      compare(rs1_o, e_r1[r], "rs1_o");
      compare(rs2_valid_o, e_r2v[r], "rs2_valid_o");
      compare(rs2_o, e_r2[r], "rs2_o");
    end
    if (f_clb[r]) compare(rd_clobber_o[e_creg[r]], e_cfu_reg[r], "rd_clobber_o");
    if (f_clb_none[r]) begin
      for (int i = 0; i < 32; i++) compare(rd_clobber_o[i], sb_pkg::FU_NONE, "rd_clobber_o");
    end
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    test_name = '{"", "issue order and full", "write-back and in-order commit",
                  "auto-completion", "clobber table", "forwarding", "flush"};
    build_table();
    table_ready = 1'b1;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      @(posedge clk_i);
      dec_valid_i <= t_dv[r];
      issue_ack_i <= t_ack[r];
      dec_rd_i <= t_rd[r];
      dec_fu_i <= t_fu[r];
      wb_valid_i <= t_wbv[r];
      wb_trans_id_i <= {t_wbid[r][1], t_wbid[r][0]};
      wb_data_i <= {t_wbd[r][1], t_wbd[r][0]};
      commit_ack_i <= t_cack[r];
      flush_i <= t_flush[r];
      rs1_i <= t_rs1[r];
      rs2_i <= t_rs2[r];
      @(negedge clk_i);
      check_row(r);
      if (r == n_rows - 1 || t_test[r+1] != t_test[r]) begin
        $display("test %0d %s: %s", t_test[r], test_name[t_test[r]],
                 test_errors == 0 ? "ok" : "mismatches");
        test_errors = 0;
      end
    end
    $display("checks: %0d run, %0d failed, %0d assertion failures", checks, errors,
             scoreboard_inst.sva_inst.fail_cnt);
    if (errors == 0 && scoreboard_inst.sva_inst.fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    wait (table_ready);
    #((n_rows + 20) * 8);
    $display("watchdog: the run did not finish in time, test timed out");
    $display("Test failed");
    $finish;
  end

endmodule

/* tests/scoreboard_sva.sv */
// bound assertions on scoreboard handshakes, write-back IDs and the x0 clobber entry
`timescale 1ns/1ps

module scoreboard_sva #(
  parameter int unsigned NR_ENTRIES  = 8,
  parameter int unsigned NR_WB_PORTS = 2
) (
  input logic                                           clk_i,
  input logic                                           rst_ni,
  input logic                                           commit_ack_i,
  input logic                                           commit_valid_o,
  input logic                                           issue_ack_i,
  input logic                                           issue_valid_o,
  input logic [NR_WB_PORTS-1:0]                         wb_valid_i,
  input logic [NR_WB_PORTS-1:0][$clog2(NR_ENTRIES)-1:0] wb_trans_id_i,
  input sb_pkg::fu_e [sb_pkg::NR_REGS-1:0]              rd_clobber_o
);

  // number of assertion failures seen so far
  int unsigned fail_cnt = 0;

  // x0 is never a pending destination
  a_x0_clobber: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_clobber_o[0] == sb_pkg::FU_NONE) else begin
    $error("x0 shows a pending unit");
    fail_cnt++;
  end

  // ack only an offered head
  a_commit_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_i |-> commit_valid_o) else begin
    $error("commit ack without commit valid");
    fail_cnt++;
  end

  a_issue_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_valid_o) else begin
    $error("issue ack without issue valid");
    fail_cnt++;
  end

  // each pair of write-back ports carries distinct IDs
  for (genvar a = 0; a < NR_WB_PORTS; a++) begin : gen_pa
    for (genvar b = a + 1; b < NR_WB_PORTS; b++) begin : gen_pb
      a_wb_unique: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_valid_i[a] && wb_valid_i[b]) |-> (wb_trans_id_i[a] != wb_trans_id_i[b]))
        else begin
        $error("two write-back ports share one transaction ID");
        fail_cnt++;
      end
    end
  end

endmodule

bind scoreboard scoreboard_sva #(
  .NR_ENTRIES  (NR_ENTRIES),
  .NR_WB_PORTS (NR_WB_PORTS)
) sva_inst (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .commit_ack_i   (commit_ack_i),
  .commit_valid_o (commit_valid_o),
  .issue_ack_i    (issue_ack_i),
  .issue_valid_o  (issue_valid_o),
  .wb_valid_i     (wb_valid_i),
  .wb_trans_id_i  (wb_trans_id_i),
  .rd_clobber_o   (rd_clobber_o)
);

/* rtl/scoreboard.sv */
// in-order instruction scoreboard top level joining entry store, clobber table and forwarding
`timescale 1ns/1ps

module scoreboard #(
  // queue depth, power of two
  parameter int unsigned NR_ENTRIES  = 8,
  parameter int unsigned NR_WB_PORTS = 2
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           flush_i,
  // issue side
  input  logic                                           dec_valid_i,
  input  logic [sb_pkg::REG_ADDR_W-1:0]                  dec_rd_i,
  input  sb_pkg::fu_e                                    dec_fu_i,
  input  logic                                           issue_ack_i,
  output logic                                           issue_valid_o,
  output logic                                           dec_ack_o,
  output logic [$clog2(NR_ENTRIES)-1:0]                  issue_trans_id_o,
  output logic                                           sb_full_o,
  // write-back side
  input  logic [NR_WB_PORTS-1:0]                         wb_valid_i,
  input  logic [NR_WB_PORTS-1:0][$clog2(NR_ENTRIES)-1:0] wb_trans_id_i,
  input  logic [NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]       wb_data_i,
  // commit side
  output logic                                           commit_valid_o,
  output logic [$clog2(NR_ENTRIES)-1:0]                  commit_trans_id_o,
  output logic [sb_pkg::REG_ADDR_W-1:0]                  commit_rd_o,
  output sb_pkg::fu_e                                    commit_fu_o,
  output logic [sb_pkg::XLEN-1:0]                        commit_result_o,
  input  logic                                           commit_ack_i,
  // operand read side
  input  logic [sb_pkg::REG_ADDR_W-1:0]                  rs1_i,
  input  logic [sb_pkg::REG_ADDR_W-1:0]                  rs2_i,
  output logic [sb_pkg::XLEN-1:0]                        rs1_o,
  output logic                                           rs1_valid_o,
  output logic [sb_pkg::XLEN-1:0]                        rs2_o,
  output logic                                           rs2_valid_o,
  // pending writer per register
  output sb_pkg::fu_e [sb_pkg::NR_REGS-1:0]              rd_clobber_o
);

  // per-slot state shared by the clobber table and forwarding
  logic [NR_ENTRIES-1:0]                         entry_issued;
  logic [NR_ENTRIES-1:0]                         entry_valid;
  logic [NR_ENTRIES-1:0][sb_pkg::REG_ADDR_W-1:0] entry_rd;
  sb_pkg::fu_e [NR_ENTRIES-1:0]                  entry_fu;
  logic [NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]       entry_result;

  // ----------------------------------------------------------
  // queue of issued instructions
  // ----------------------------------------------------------
  sb_entry_store #(
    .NR_ENTRIES  (NR_ENTRIES),
    .NR_WB_PORTS (NR_WB_PORTS)
  ) entry_store_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (flush_i),
    .dec_valid_i       (dec_valid_i),
    .dec_rd_i          (dec_rd_i),
    .dec_fu_i          (dec_fu_i),
    .issue_ack_i       (issue_ack_i),
    .issue_valid_o     (issue_valid_o),
    .dec_ack_o         (dec_ack_o),
    .issue_trans_id_o  (issue_trans_id_o),
    .sb_full_o         (sb_full_o),
    .wb_valid_i        (wb_valid_i),
    .wb_trans_id_i     (wb_trans_id_i),
    .wb_data_i         (wb_data_i),
    .commit_valid_o    (commit_valid_o),
    .commit_trans_id_o (commit_trans_id_o),
    .commit_rd_o       (commit_rd_o),
    .commit_fu_o       (commit_fu_o),
    .commit_result_o   (commit_result_o),
    .commit_ack_i      (commit_ack_i),
    .entry_issued_o    (entry_issued),
    .entry_valid_o     (entry_valid),
    .entry_rd_o        (entry_rd),
    .entry_fu_o        (entry_fu),
    .entry_result_o    (entry_result)
  );

  // ----------------------------------------------------------
  // destination hazards
  // ----------------------------------------------------------
  sb_clobber_table #(
    .NR_ENTRIES (NR_ENTRIES)
  ) clobber_table_inst (
    .entry_issued_i (entry_issued),
    .entry_rd_i     (entry_rd),
    .entry_fu_i     (entry_fu),
    .rd_clobber_o   (rd_clobber_o)
  );

  // ----------------------------------------------------------
  // source operand bypass
  // ----------------------------------------------------------
  sb_operand_fwd #(
    .NR_ENTRIES  (NR_ENTRIES),
    .NR_WB_PORTS (NR_WB_PORTS)
  ) operand_fwd_inst (
    .rs1_i          (rs1_i),
    .rs2_i          (rs2_i),
    .wb_valid_i     (wb_valid_i),
    .wb_trans_id_i  (wb_trans_id_i),
    .wb_data_i      (wb_data_i),
    .entry_issued_i (entry_issued),
    .entry_valid_i  (entry_valid),
    .entry_rd_i     (entry_rd),
    .entry_result_i (entry_result),
    .rs1_o          (rs1_o),
    .rs1_valid_o    (rs1_valid_o),
    .rs2_o          (rs2_o),
    .rs2_valid_o    (rs2_valid_o)
  );

endmodule

/* rtl/sb_operand_fwd.sv */
// rs1/rs2 operand forwarding from write-back ports and completed scoreboard entries
`timescale 1ns/1ps

module sb_operand_fwd #(
  parameter int unsigned NR_ENTRIES  = 8,
  parameter int unsigned NR_WB_PORTS = 2
) (
  // source register addresses
  input  logic [sb_pkg::REG_ADDR_W-1:0]                  rs1_i,
  input  logic [sb_pkg::REG_ADDR_W-1:0]                  rs2_i,
  // write-back ports, same cycle bypass
  input  logic [NR_WB_PORTS-1:0]                         wb_valid_i,
  input  logic [NR_WB_PORTS-1:0][$clog2(NR_ENTRIES)-1:0] wb_trans_id_i,
  input  logic [NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]       wb_data_i,
  // per-slot view from the entry store
  input  logic [NR_ENTRIES-1:0]                          entry_issued_i,
  input  logic [NR_ENTRIES-1:0]                          entry_valid_i,
  input  logic [NR_ENTRIES-1:0][sb_pkg::REG_ADDR_W-1:0]  entry_rd_i,
  input  logic [NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]        entry_result_i,
  // forwarded operands
  output logic [sb_pkg::XLEN-1:0]                        rs1_o,
  output logic                                           rs1_valid_o,
  output logic [sb_pkg::XLEN-1:0]                        rs2_o,
  output logic                                           rs2_valid_o
);

  // index 0 is rs1, index 1 is rs2
  logic [sb_pkg::REG_ADDR_W-1:0] src_addr [2];
  logic [sb_pkg::XLEN-1:0]       src_data [2];
  logic                          src_valid [2];

  assign src_addr[0] = rs1_i;
  assign src_addr[1] = rs2_i;

  // ----------------------------------------------------------
  // per-source fixed-priority select
  // ----------------------------------------------------------
  for (genvar s = 0; s < 2; s++) begin : gen_src
    always_comb begin : sel
      src_valid[s] = 1'b0;
      src_data[s]  = '0;
      // completed entries, lowest slot ends up on top
      for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
        if (entry_issued_i[i] && entry_valid_i[i] && (entry_rd_i[i] == src_addr[s])) begin
          src_valid[s] = 1'b1;
          src_data[s]  = entry_result_i[i];
        end
      end
      // result on a write-back port is newer than anything stored
      for (int p = NR_WB_PORTS - 1; p >= 0; p--) begin
        if (wb_valid_i[p] && entry_issued_i[wb_trans_id_i[p]] &&
            (entry_rd_i[wb_trans_id_i[p]] == src_addr[s])) begin
          src_valid[s] = 1'b1;
          src_data[s]  = wb_data_i[p];
        end
      end
      // x0 always comes from the register file
      if (src_addr[s] == '0) begin
        src_valid[s] = 1'b0;
        src_data[s]  = '0;
      end
    end
  end

  assign rs1_o       = src_data[0];
  assign rs1_valid_o = src_valid[0];
  assign rs2_o       = src_data[1];
  assign rs2_valid_o = src_valid[1];

endmodule

/* rtl/sb_clobber_table.sv */
// clobber table giving the functional unit that will write each integer register
`timescale 1ns/1ps

module sb_clobber_table #(
  parameter int unsigned NR_ENTRIES = 8
) (
  // per-slot view from the entry store
  input  logic [NR_ENTRIES-1:0]                         entry_issued_i,
  input  logic [NR_ENTRIES-1:0][sb_pkg::REG_ADDR_W-1:0] entry_rd_i,
  input  sb_pkg::fu_e [NR_ENTRIES-1:0]                  entry_fu_i,
  // one unit per register, FU_NONE when nothing is pending
  output sb_pkg::fu_e [sb_pkg::NR_REGS-1:0]             rd_clobber_o
);

  localparam int unsigned RA_W = sb_pkg::REG_ADDR_W;

  // ----------------------------------------------------------
  // register match matrix
  // ----------------------------------------------------------

  // hit[r][i] when slot i is issued and writes register r
  logic [sb_pkg::NR_REGS-1:0][NR_ENTRIES-1:0] hit;

  always_comb begin : match
    for (int unsigned r = 0; r < sb_pkg::NR_REGS; r++) begin
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        hit[r][i] = entry_issued_i[i] & (entry_rd_i[i] == RA_W'(r));
      end
    end
    // x0 is hardwired, a write to it is never a hazard
    hit[0] = '0;
  end

  // ----------------------------------------------------------
  // fixed-priority select, lowest slot index wins
  // ----------------------------------------------------------
  always_comb begin : select
    for (int unsigned r = 0; r < sb_pkg::NR_REGS; r++) begin
      rd_clobber_o[r] = sb_pkg::FU_NONE;
      // walk down so that the lowest hit is assigned last
      for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
        if (hit[r][i]) begin
          rd_clobber_o[r] = entry_fu_i[i];
        end
      end
    end
  end

endmodule

/* rtl/sb_entry_store.sv */
// scoreboard entry queue with issue, write-back, auto-completion, commit and flush
`timescale 1ns/1ps

module sb_entry_store #(
  // queue depth as a power of two
  parameter int unsigned NR_ENTRIES  = 8,
  parameter int unsigned NR_WB_PORTS = 2
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  flush_i,
  // decoded instruction from the decoder
  input  logic                                                  dec_valid_i,
  input  logic [sb_pkg::REG_ADDR_W-1:0]                         dec_rd_i,
  input  sb_pkg::fu_e                                           dec_fu_i,
  input  logic                                                  issue_ack_i,
  output logic                                                  issue_valid_o,
  output logic                                                  dec_ack_o,
  output logic [$clog2(NR_ENTRIES)-1:0]                         issue_trans_id_o,
  output logic                                                  sb_full_o,
  // write-back ports
  input  logic [NR_WB_PORTS-1:0]                                wb_valid_i,
  input  logic [NR_WB_PORTS-1:0][$clog2(NR_ENTRIES)-1:0]        wb_trans_id_i,
  input  logic [NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]              wb_data_i,
  // commit port showing the head of the queue
  output logic                                                  commit_valid_o,
  output logic [$clog2(NR_ENTRIES)-1:0]                         commit_trans_id_o,
  output logic [sb_pkg::REG_ADDR_W-1:0]                         commit_rd_o,
  output sb_pkg::fu_e                                           commit_fu_o,
  output logic [sb_pkg::XLEN-1:0]                               commit_result_o,
  input  logic                                                  commit_ack_i,
  // per-slot view for clobber table and forwarding
  output logic [NR_ENTRIES-1:0]                                 entry_issued_o,
  output logic [NR_ENTRIES-1:0]                                 entry_valid_o,
  output logic [NR_ENTRIES-1:0][sb_pkg::REG_ADDR_W-1:0]         entry_rd_o,
  output sb_pkg::fu_e [NR_ENTRIES-1:0]                          entry_fu_o,
  output logic [NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]               entry_result_o
);

  localparam int unsigned ID_W = $clog2(NR_ENTRIES);

  // slot control bits
  logic [NR_ENTRIES-1:0] issued_q, issued_d;
  logic [NR_ENTRIES-1:0] valid_q, valid_d;
  // slot payload
  logic [NR_ENTRIES-1:0][sb_pkg::REG_ADDR_W-1:0] rd_q;
  sb_pkg::fu_e [NR_ENTRIES-1:0]                  fu_q;
  logic [NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]       result_q;

  // pointers and occupancy
  logic [ID_W-1:0] issue_ptr_q, commit_ptr_q, cnt_q;
  logic            issue_full;
  logic            issue_en;
  logic            commit_en;

  // ----------------------------------------------------------
  // issue handshake
  // ----------------------------------------------------------

  // one slot is kept free so full means NR_ENTRIES-1 in flight
  assign issue_full       = (cnt_q == ID_W'(NR_ENTRIES - 1));
  assign sb_full_o        = issue_full;
  assign issue_valid_o    = dec_valid_i & ~issue_full;
  assign dec_ack_o        = issue_ack_i & ~issue_full;
  assign issue_trans_id_o = issue_ptr_q;

  // flush takes precedence over an accepted instruction
  assign issue_en = dec_valid_i & dec_ack_o & ~flush_i;

  // ----------------------------------------------------------
  // commit port
  // ----------------------------------------------------------

  // head is offered once it is issued and has its result
  assign commit_valid_o    = issued_q[commit_ptr_q] & valid_q[commit_ptr_q];
  assign commit_trans_id_o = commit_ptr_q;
  assign commit_rd_o       = rd_q[commit_ptr_q];
  assign commit_fu_o       = fu_q[commit_ptr_q];
  assign commit_result_o   = result_q[commit_ptr_q];

  // only retire a head that is actually offered
  assign commit_en = commit_ack_i & commit_valid_o & ~flush_i;

  // ----------------------------------------------------------
  // next state of the slot control bits
  // ----------------------------------------------------------
  always_comb begin : ctrl_next
    issued_d = issued_q;
    valid_d  = valid_q;
    // entries without a unit complete one cycle after issue
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (issued_q[i] && (fu_q[i] == sb_pkg::FU_NONE)) begin
        valid_d[i] = 1'b1;
      end
    end
    // stale write-back IDs after a flush hit free slots and are dropped
    for (int unsigned p = 0; p < NR_WB_PORTS; p++) begin
      if (wb_valid_i[p] && issued_q[wb_trans_id_i[p]]) begin
        valid_d[wb_trans_id_i[p]] = 1'b1;
      end
    end
    // retire the head
    if (commit_en) begin
      issued_d[commit_ptr_q] = 1'b0;
      valid_d[commit_ptr_q]  = 1'b0;
    end
    // new entry starts without a result
    if (issue_en) begin
      issued_d[issue_ptr_q] = 1'b1;
      valid_d[issue_ptr_q]  = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      issued_q     <= '0;
      valid_q      <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else if (flush_i) begin
      // full flush empties every slot
      issued_q     <= '0;
      valid_q      <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      issued_q     <= issued_d;
      valid_q      <= valid_d;
      // pointers wrap since the depth is a power of two
      issue_ptr_q  <= issue_ptr_q + ID_W'(issue_en);
      commit_ptr_q <= commit_ptr_q + ID_W'(commit_en);
      cnt_q        <= cnt_q + ID_W'(issue_en) - ID_W'(commit_en);
    end
  end

  // ----------------------------------------------------------
  // slot payload
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin : payload_regs
    // higher port is written last and wins on a shared ID
    for (int unsigned p = 0; p < NR_WB_PORTS; p++) begin
      if (wb_valid_i[p] && issued_q[wb_trans_id_i[p]]) begin
        result_q[wb_trans_id_i[p]] <= wb_data_i[p];
      end
    end
    if (issue_en) begin
      rd_q[issue_ptr_q]     <= dec_rd_i;
      fu_q[issue_ptr_q]     <= dec_fu_i;
      result_q[issue_ptr_q] <= '0;
    end
  end

  assign entry_issued_o = issued_q;
  assign entry_valid_o  = valid_q;
  assign entry_rd_o     = rd_q;
  assign entry_fu_o     = fu_q;
  assign entry_result_o = result_q;

endmodule

/* rtl/sb_pkg.sv */
// scoreboard package with register, data widths and functional-unit encoding
package sb_pkg;

  // ----------------------------------------------------------
  // register file geometry
  // ----------------------------------------------------------

  // width of an integer register address
  localparam int unsigned REG_ADDR_W = 5;

  // number of integer registers, x0 included
  localparam int unsigned NR_REGS = 2 ** REG_ADDR_W;

  // ----------------------------------------------------------
  // datapath
  // ----------------------------------------------------------

  // width of a result returned by a functional unit
  localparam int unsigned XLEN = 32;

  // ----------------------------------------------------------
  // functional units
  // ----------------------------------------------------------

  // unit that executes an instruction and later writes its rd
  // FU_NONE means no unit is involved and the entry completes by itself
  typedef enum logic [2:0] {
    // no execution needed, e.g. nop or a fence
    FU_NONE   = 3'd0,
    // integer alu
    FU_ALU    = 3'd1,
    // load unit
    FU_LOAD   = 3'd2,
    // store unit
    FU_STORE  = 3'd3,
    // multiplier / divider
    FU_MULT   = 3'd4,
    // branch unit
    FU_BRANCH = 3'd5,
    // csr access
    FU_CSR    = 3'd6
  } fu_e;

endpackage
